/* Bender.yml */
package:
  name: stm_swapchain

sources:
  - hw/stm_params_pkg.sv
  - hw/stm_types_pkg.sv
  - hw/ec_time_to_sys_time.sv
  - hw/stm_timer.sv
  - hw/stm_swapchain.sv
  - hw/stm_top.sv
  - target: test
    files:
      - tb/stm_props.sv
      - tb/stm_tb.sv

/* hw/ec_time_to_sys_time.sv */
module ec_time_to_sys_time
  import stm_params_pkg::*;
(
  input  logic                  CLK,
  input  logic                  rst_n,
  input  logic [63:0]           ec_time,
  input  logic [8:0]            ufreq_mult,
  input  logic                  din_valid,
  output logic [time_width-1:0] sys_time_out,
  output logic                  dout_valid
);

  logic [63:0] ec_q;
  logic [8:0]  mult_q;
  logic [72:0] prod_q;  // full product that the last stage truncates
  logic        vld_1;
  logic        vld_2;

  // the data path has three register stages
  always_ff @(posedge CLK) begin
    ec_q <= ec_time;
    mult_q <= ufreq_mult;
    prod_q <= ec_q * mult_q;
    sys_time_out <= prod_q[time_width-1:0];
  end

  // valid bit follows the data through each stage
  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      vld_1 <= 1'b0;
      vld_2 <= 1'b0;
      dout_valid <= 1'b0;
    end else begin
      vld_1 <= din_valid;
      vld_2 <= vld_1;
      dout_valid <= vld_2;
    end
  end

endmodule

/* hw/stm_params_pkg.sv */
package stm_params_pkg;

  localparam int num_segment = 2;
  localparam int idx_width = 13;
  localparam int time_width = 56;

  localparam logic [15:0] rep_infinite = 16'hFFFF;  // repeat value meaning loop forever

  // transition mode codes as written by the host
  localparam logic [7:0] transition_mode_sync_idx = 8'h00;
  localparam logic [7:0] transition_mode_sys_time = 8'h01;
  localparam logic [7:0] transition_mode_gpio = 8'h02;
  localparam logic [7:0] transition_mode_ext = 8'hF0;

  localparam int sub_latency = 5;  // depth of the time-difference pipeline

endpackage

/* hw/stm_swapchain.sv */
module stm_swapchain
  import stm_params_pkg::*;
  import stm_types_pkg::*;
#(
  parameter int sub_latency_p = sub_latency
) (
  input  logic                                  CLK,
  input  logic                                  rst_n,
  input  logic [time_width-1:0]                 sys_time,
  input  logic                                  update_settings,
  input  stm_settings_t                         settings,
  input  segment_cfg_t [num_segment-1:0]        seg_cfg,
  input  logic [num_segment-1:0][idx_width-1:0] sync_idx,
  input  logic [3:0]                            gpio_in,
  input  logic [time_width-1:0]                 conv_time,
  input  logic                                  conv_valid,
  output logic                                  conv_din_valid,
  output stm_status_t                           status
);

  typedef enum logic [1:0] {
    wait_start,
    finite_loop,
    infinite_loop
  } state_t;

  typedef enum logic {
    idx_mode_sync,
    idx_mode_tic
  } idx_mode_t;

  state_t    state;
  idx_mode_t idx_mode;
  logic      segment;
  logic      stop;
  logic      ext_mode;

  // request latched at update_settings
  logic        req_segment;
  logic [15:0] rep_lim;
  logic [7:0]  mode_q;
  logic [1:0]  gpio_sel;
  logic [15:0] loop_cnt;

  logic [num_segment-1:0][idx_width-1:0] idx_old;
  logic [num_segment-1:0][idx_width-1:0] tic_idx;
  logic [num_segment-1:0]                changed;
  logic [num_segment-1:0]                wrap;

  logic [time_width-1:0]                  tgt_time;
  logic                                   tgt_valid;
  logic [sub_latency_p-1:0][time_width:0] diff_q;  // msb is the sign
  logic [sub_latency_p-1:0]               diff_vld;
  logic                                   time_arrived;

  logic upd_infinite;
  logic start_hit;
  logic start_tic;
  logic loop_tick;

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      idx_old <= '0;
    end else begin
      idx_old <= sync_idx;
    end
  end

  always_comb begin
    for (int k = 0; k < num_segment; k++) begin
      changed[k] = idx_old[k] != sync_idx[k];
      wrap[k] = changed[k] && (sync_idx[k] == '0);
    end
  end

  // the converted target time goes through a registered subtraction
  always_ff @(posedge CLK) begin
    if (conv_valid) begin
      tgt_time <= conv_time;
    end
    diff_q[0] <= {1'b0, sys_time} - {1'b0, tgt_time};
    for (int k = 1; k < sub_latency_p; k++) begin
      diff_q[k] <= diff_q[k-1];
    end
  end

  always_ff @(posedge CLK) begin
    if (!rst_n || update_settings) begin
      tgt_valid <= 1'b0;
      diff_vld <= '0;
    end else begin
      if (conv_valid) begin
        tgt_valid <= 1'b1;
      end
      diff_vld[0] <= tgt_valid;
      for (int k = 1; k < sub_latency_p; k++) begin
        diff_vld[k] <= diff_vld[k-1];
      end
    end
  end

  assign time_arrived = diff_vld[sub_latency_p-1] && !diff_q[sub_latency_p-1][time_width];

  assign upd_infinite = seg_cfg[settings.req_rd_segment].rep == rep_infinite;

  always_comb begin
    start_hit = 1'b0;
    start_tic = 1'b0;
    case (mode_q)
      transition_mode_sync_idx: start_hit = wrap[req_segment];
      transition_mode_sys_time: begin
        start_hit = time_arrived;
        start_tic = 1'b1;
      end
      transition_mode_gpio: begin
        start_hit = changed[req_segment] && gpio_in[gpio_sel];
        start_tic = 1'b1;
      end
      default: ;
    endcase
  end

  // in tic mode a loop ends when the tic counter wraps
  always_comb begin
    if (idx_mode == idx_mode_sync) begin
      loop_tick = wrap[segment];
    end else begin
      loop_tick = changed[segment] && (tic_idx[segment] == seg_cfg[segment].cycle);
    end
  end

  always_ff @(posedge CLK) begin
    if (!rst_n) begin
      state <= infinite_loop;
      idx_mode <= idx_mode_sync;
      segment <= 1'b0;
      stop <= 1'b0;
      ext_mode <= 1'b0;
      req_segment <= 1'b0;
      rep_lim <= '0;
      mode_q <= transition_mode_sync_idx;
      gpio_sel <= '0;
      loop_cnt <= '0;
      tic_idx <= '0;
      conv_din_valid <= 1'b0;
    end else begin
      conv_din_valid <= 1'b0;
      if (update_settings) begin
        if (upd_infinite) begin
          stop <= 1'b0;
          segment <= settings.req_rd_segment;
          idx_mode <= idx_mode_sync;
          ext_mode <= settings.transition_mode == transition_mode_ext;
          state <= infinite_loop;
        end else begin
          req_segment <= settings.req_rd_segment;
          rep_lim <= seg_cfg[settings.req_rd_segment].rep;
          mode_q <= settings.transition_mode;
          gpio_sel <= settings.transition_value[1:0];
          ext_mode <= 1'b0;
          conv_din_valid <= settings.transition_mode == transition_mode_sys_time;
          state <= wait_start;
        end
      end else begin
        case (state)
          wait_start: begin  // old segment keeps playing until the trigger
            if (start_hit) begin
              stop <= 1'b0;
              loop_cnt <= '0;
              segment <= req_segment;
              idx_mode <= start_tic ? idx_mode_tic : idx_mode_sync;
              tic_idx[req_segment] <= '0;
              state <= finite_loop;
            end
          end
          finite_loop: begin
            if (idx_mode == idx_mode_tic && changed[segment]) begin
              tic_idx[segment] <= loop_tick ? '0 : tic_idx[segment] + 1'b1;
            end
            if (loop_tick) begin
              if (loop_cnt == rep_lim) begin
                stop <= 1'b1;
              end else begin
                loop_cnt <= loop_cnt + 16'd1;
              end
            end
          end
          infinite_loop: begin
            if (ext_mode && wrap[segment]) begin
              segment <= ~segment;
            end
          end
          default: state <= infinite_loop;
        endcase
      end
    end
  end

  always_comb begin
    status.stop = stop;
    status.segment = segment;
    for (int k = 0; k < num_segment; k++) begin
      status.idx[k] = (idx_mode == idx_mode_sync) ? idx_old[k] : tic_idx[k];
    end
  end

endmodule

/* hw/stm_timer.sv */
module stm_timer
  import stm_params_pkg::*;
  import stm_types_pkg::*;
(
  input  logic                                  CLK,
  input  logic                                  rst_n,
  input  segment_cfg_t [num_segment-1:0]        seg_cfg,
  output logic [num_segment-1:0][idx_width-1:0] sync_idx
);

  logic [idx_width-1:0] idx_q [num_segment];

  for (genvar i = 0; i < num_segment; i++) begin : gen_seg
    logic [15:0] presc;
    logic        step;

    assign step = presc == seg_cfg[i].freq_div - 16'd1;  // prescaler wraps here

    always_ff @(posedge CLK) begin
      if (!rst_n) begin
        presc <= '0;
        idx_q[i] <= '0;
      end else if (step) begin
        presc <= '0;
        // a cycle shortened on the fly still wraps
        if (idx_q[i] >= seg_cfg[i].cycle) begin
          idx_q[i] <= '0;
        end else begin
          idx_q[i] <= idx_q[i] + 1'b1;
        end
      end else begin
        presc <= presc + 16'd1;
      end
    end
  end

  always_comb begin
    for (int k = 0; k < num_segment; k++) begin
      sync_idx[k] = idx_q[k];
    end
  end

endmodule

/* hw/stm_top.sv */
module stm_top
  import stm_params_pkg::*;
  import stm_types_pkg::*;
#(
  parameter int sub_latency_p = sub_latency
) (
  input  logic                           CLK,
  input  logic                           rst_n,
  input  logic [time_width-1:0]          sys_time,
  input  logic                           update_settings,
  input  stm_settings_t                  settings,
  input  segment_cfg_t [num_segment-1:0] seg_cfg,
  input  logic [3:0]                     gpio_in,
  output stm_status_t                    status
);

  logic [num_segment-1:0][idx_width-1:0] sync_idx;
  logic [time_width-1:0]                 conv_time;
  logic                                  conv_valid;
  logic                                  conv_din_valid;

  stm_timer stm_timer_inst (
    .CLK     (CLK),
    .rst_n   (rst_n),
    .seg_cfg (seg_cfg),
    .sync_idx(sync_idx)
  );

  // transition time is converted straight from the host settings
  ec_time_to_sys_time ec_time_to_sys_time_inst (
    .CLK         (CLK),
    .rst_n       (rst_n),
    .ec_time     (settings.transition_value),
    .ufreq_mult  (settings.ufreq_mult),
    .din_valid   (conv_din_valid),
    .sys_time_out(conv_time),
    .dout_valid  (conv_valid)
  );

  stm_swapchain #(
    .sub_latency_p(sub_latency_p)
  ) stm_swapchain_inst (
    .CLK            (CLK),
    .rst_n          (rst_n),
    .sys_time       (sys_time),
    .update_settings(update_settings),
    .settings       (settings),
    .seg_cfg        (seg_cfg),
    .sync_idx       (sync_idx),
    .gpio_in        (gpio_in),
    .conv_time      (conv_time),
    .conv_valid     (conv_valid),
    .conv_din_valid (conv_din_valid),
    .status         (status)
  );

endmodule

/* hw/stm_types_pkg.sv */
package stm_types_pkg;

  import stm_params_pkg::*;

  // one pattern segment as configured by the host
  typedef struct packed {
    logic [idx_width-1:0] cycle;     // last index of the segment
    logic [15:0]          freq_div;  // clocks per index step
    logic [15:0]          rep;       // loops minus one, or rep_infinite
  } segment_cfg_t;

  typedef struct packed {
    logic        req_rd_segment;
    logic [7:0]  transition_mode;
    logic [63:0] transition_value;  // ec time, or gpio bit select
    logic [8:0]  ufreq_mult;
  } stm_settings_t;

  typedef struct packed {
    logic                                  stop;
    logic                                  segment;
    logic [num_segment-1:0][idx_width-1:0] idx;
  } stm_status_t;

endpackage

/* tb/stm_props.sv */
module stm_props
  import stm_params_pkg::*;
  import stm_types_pkg::*;
(
  input logic                           CLK,
  input logic                           rst_n,
  input logic                           update_settings,
  input logic [1:0]                     state,
  input logic                           idx_mode,
  input logic                           segment,
  input logic [num_segment-1:0]         changed,
  input segment_cfg_t [num_segment-1:0] seg_cfg,
  input stm_status_t                    status
);

  localparam logic [1:0] st_finite = 2'd1;
  localparam logic [1:0] st_infinite = 2'd2;

  int prop_fails = 0;

  logic [idx_width-1:0] cur_idx;
  logic [idx_width-1:0] tic_next;
  logic                 tic_run;

  assign cur_idx = status.idx[segment];
  assign tic_run = state == st_finite && idx_mode && !update_settings;
  // tic index steps on a change of the playing segment and wraps after cycle
  assign tic_next = !changed[segment] ? cur_idx :
                    (cur_idx == seg_cfg[segment].cycle) ? '0 : cur_idx + 1'b1;

  no_stop_in_infinite: assert property (@(posedge CLK) disable iff (!rst_n)
    state == st_infinite |-> !status.stop)
  else begin
    $error("stop is set while looping forever");
    prop_fails++;
  end

  tic_starts_at_zero: assert property (@(posedge CLK) disable iff (!rst_n)
    $rose(state == st_finite) && idx_mode |-> cur_idx == '0)
  else begin
    $error("tic index does not start at zero after the switch");
    prop_fails++;
  end

  tic_follows_changes: assert property (@(posedge CLK) disable iff (!rst_n)
    tic_run |=> cur_idx == $past(tic_next))
  else begin
    $error("tic index does not follow the index changes");
    prop_fails++;
  end

  finite_keeps_segment: assert property (@(posedge CLK) disable iff (!rst_n)
    state == st_finite && !update_settings |=> $stable(segment))
  else begin
    $error("segment changed while a finite loop was playing");
    prop_fails++;
  end

endmodule

bind stm_swapchain stm_props stm_props_inst (
  .CLK            (CLK),
  .rst_n          (rst_n),
  .update_settings(update_settings),
  .state          (state),
  .idx_mode       (idx_mode),
  .segment        (segment),
  .changed        (changed),
  .seg_cfg        (seg_cfg),
  .status         (status)
);

/* tb/stm_tb.sv */
module stm_tb
  import stm_params_pkg::*;
  import stm_types_pkg::*;
();

  localparam int clk_period = 10;
  localparam int test_cycles = 16 + 40 + 33 + 101 + 141 + 131 + 161 + 10;  // phase budgets in order

  typedef enum logic [1:0] {
    m_pending,
    m_finite,
    m_infinite
  } model_state_t;

  logic                           CLK;
  logic                           rst_n;
  logic [time_width-1:0]          sys_time;
  logic                           update_settings;
  stm_settings_t                  settings;
  segment_cfg_t [num_segment-1:0] seg_cfg;
  logic [3:0]                     gpio_in;
  stm_status_t                    status;

  int         val_errs = 0;
  int         other_errs = 0;
  int         prop_fails;
  logic [7:0] lfsr = 8'd90;

  // reference model of the timer and the segment rules
  logic [num_segment-1:0][15:0]          m_presc;
  logic [num_segment-1:0][idx_width-1:0] m_idx;
  logic [num_segment-1:0][idx_width-1:0] m_old;
  logic [num_segment-1:0]                m_chg;
  logic [num_segment-1:0]                m_wrap;
  model_state_t                          m_state;
  logic                                  exp_seg;
  logic                                  exp_stop;
  logic                                  m_req;
  logic                                  m_tic;
  logic                                  m_ext;
  logic                                  m_dc;  // either segment is allowed in the sys_time window
  logic                                  m_switch;
  logic [7:0]                            m_mode;
  logic [1:0]                            m_sel;
  logic [15:0]                           m_rep;
  logic [15:0]                           m_loops;
  logic [time_width-1:0]                 m_tgt;

  stm_top stm_top_inst (.*);

  // galois lfsr with taps x^8 + x^6 + x^5 + x^4 + 1
  function automatic logic [7:0] lfsr_next(input logic [7:0] s);
    return s[0] ? ((s >> 1) ^ 8'hB8) : (s >> 1);
  endfunction

  task automatic next_cycle();
    @(posedge CLK);
    #1;
  endtask

  task automatic check_value(input string name, input int unsigned expv, input int unsigned actv);
    assert (expv == actv) else begin
      val_errs++;
      $display("ERROR %0t %s expected %0d actual %0d", $time, name, expv, actv);
    end
  endtask

  task automatic send_update(input logic seg, input logic [7:0] mode, input logic [63:0] value,
                             input logic [8:0] mult);
    settings = {seg, mode, value, mult};
    update_settings = 1'b1;
    next_cycle();
    update_settings = 1'b0;
  endtask

  task automatic wait_status(input logic stop_v, input logic seg_v, input int limit,
                             input string what);
    int n = 0;
    while ({status.stop, status.segment} != {stop_v, seg_v} && n < limit) begin
      next_cycle();
      n++;
    end
    if ({status.stop, status.segment} != {stop_v, seg_v}) begin
      other_errs++;
      $display("%s did not happen within %0d cycles", what, limit);
    end
  endtask

  initial begin
    CLK = 1'b0;
    forever #(clk_period / 2) CLK = ~CLK;
  end

  // system time counts clocks and gpio levels are random
  always @(posedge CLK) begin
    #1;
    sys_time <= sys_time + 1'b1;
    for (int b = 0; b < 4; b++) begin
      lfsr = lfsr_next(lfsr);
      gpio_in[b] <= lfsr[0];
    end
  end

  always_comb begin
    for (int k = 0; k < num_segment; k++) begin
      m_chg[k] = m_old[k] != m_idx[k];
      m_wrap[k] = m_chg[k] && m_idx[k] == '0;
    end
    case (m_mode)
      transition_mode_sync_idx: m_switch = m_wrap[m_req];
      transition_mode_sys_time: m_switch = sys_time >= m_tgt + time_width'(sub_latency);
      transition_mode_gpio: m_switch = m_chg[m_req] && gpio_in[m_sel];
      default: m_switch = 1'b0;
    endcase
  end

  always @(posedge CLK) begin
    if (!rst_n) begin
      m_presc <= '0;
      m_idx <= '0;
      m_old <= '0;
      m_state <= m_infinite;
      exp_seg <= 1'b0;
      exp_stop <= 1'b0;
      m_tic <= 1'b0;
      m_ext <= 1'b0;
      m_dc <= 1'b0;
    end else begin
      m_old <= m_idx;
      for (int k = 0; k < num_segment; k++) begin
        if (m_presc[k] == seg_cfg[k].freq_div - 16'd1) begin
          m_presc[k] <= '0;
          m_idx[k] <= (m_idx[k] == seg_cfg[k].cycle) ? '0 : m_idx[k] + 1'b1;
        end else begin
          m_presc[k] <= m_presc[k] + 16'd1;
        end
      end
      m_dc <= 1'b0;
      if (update_settings) begin
        if (seg_cfg[settings.req_rd_segment].rep == rep_infinite) begin
          exp_seg <= settings.req_rd_segment;
          exp_stop <= 1'b0;
          m_tic <= 1'b0;
          m_ext <= settings.transition_mode == transition_mode_ext;
          m_state <= m_infinite;
        end else begin
          m_req <= settings.req_rd_segment;
          m_mode <= settings.transition_mode;
          m_sel <= settings.transition_value[1:0];
          m_rep <= seg_cfg[settings.req_rd_segment].rep;
          m_tgt <= time_width'(settings.transition_value * 64'(settings.ufreq_mult));
          m_ext <= 1'b0;
          m_state <= m_pending;
        end
      end else if (m_state == m_pending) begin
        if (m_switch) begin
          exp_seg <= m_req;
          exp_stop <= 1'b0;
          m_loops <= '0;
          m_tic <= m_mode != transition_mode_sync_idx;
          m_state <= m_finite;
        end else if (m_mode == transition_mode_sys_time && sys_time >= m_tgt) begin
          m_dc <= 1'b1;
        end
      end else if (m_state == m_finite && !m_tic && m_wrap[exp_seg]) begin
        if (m_loops == m_rep) begin
          exp_stop <= 1'b1;
        end else begin
          m_loops <= m_loops + 16'd1;
        end
      end else if (m_state == m_infinite && m_ext && m_wrap[exp_seg]) begin
        exp_seg <= ~exp_seg;
      end
    end
  end

  always @(negedge CLK) begin
    if (rst_n && !m_dc) begin
      check_value("status.segment", exp_seg, status.segment);
      check_value("status.stop", exp_stop, status.stop);
      for (int k = 0; k < num_segment; k++) begin
        if (!m_tic) begin
          check_value($sformatf("status.idx[%0d]", k), m_old[k], status.idx[k]);
        end
      end
    end
  end

  initial begin
    rst_n = 1'b0;
    sys_time = '0;
    update_settings = 1'b0;
    settings = '0;
    gpio_in = '0;
    seg_cfg[0] = {13'd7, 16'd2, 16'd1};
    seg_cfg[1] = {13'd5, 16'd2, rep_infinite};
    repeat (16) next_cycle();
    rst_n = 1'b1;
    repeat (40) next_cycle();
    send_update(1'b1, transition_mode_sync_idx, 64'd0, 9'd1);
    wait_status(1'b0, 1'b1, 2, "switch to the infinite segment 1");
    repeat (30) next_cycle();
    send_update(1'b0, transition_mode_sync_idx, 64'd0, 9'd1);
    wait_status(1'b0, 1'b0, 40, "switch to segment 0 at a wrap");
    wait_status(1'b1, 1'b0, 60, "stop after two loops of segment 0");
    seg_cfg[1].rep = 16'd100;
    send_update(1'b1, transition_mode_sys_time, 64'((sys_time + 56'd60) / 3), 9'd3);
    wait_status(1'b0, 1'b1, 100, "switch to segment 1 at the system time");
    repeat (40) next_cycle();
    seg_cfg[0].rep = 16'd100;
    send_update(1'b0, transition_mode_gpio, 64'd2, 9'd1);
    wait_status(1'b0, 1'b0, 100, "switch to segment 0 on gpio bit 2");
    repeat (30) next_cycle();
    seg_cfg[1].rep = rep_infinite;
    send_update(1'b1, transition_mode_ext, 64'd0, 9'd1);
    for (int t = 0; t < 4; t++) begin
      wait_status(1'b0, t[0], 40, "segment toggle in ext mode");
    end
    repeat (10) next_cycle();
    prop_fails = stm_top_inst.stm_swapchain_inst.stm_props_inst.prop_fails;
    $display("value errors %0d, other errors %0d, assertion failures %0d",
             val_errs, other_errs, prop_fails);
    if (val_errs + other_errs + prop_fails == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    #(20 * test_cycles * clk_period);
    $display("watchdog expired before the tests finished");
    $display("TEST RESULT: FAIL");
    $finish;
  end

endmodule

/* verilog.f */
hw/stm_params_pkg.sv
hw/stm_types_pkg.sv
hw/ec_time_to_sys_time.sv
hw/stm_timer.sv
hw/stm_swapchain.sv
hw/stm_top.sv
tb/stm_props.sv
tb/stm_tb.sv
